//--- src.f
+incdir+tb
hw/rv_isa_pkg.sv
hw/id_ctrl_pkg.sv
hw/rf_read_if.sv
hw/instr_decoder.sv
hw/operand_mux.sv
hw/reg_file.sv
hw/id_ex_reg.sv
hw/id_stage.sv
tb/id_stage_checker.sv
tb/tb_id_stage.sv

//--- run_sim.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator
verilator --binary --timing --assert --top-module tb_id_stage -f src.f \
    && ./obj_dir/Vtb_id_stage | tee /dev/stderr | grep -q "Simulation passed" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

//--- tb/id_model.svh
// reference model of the decode stage
// register values, busy bits and instruction decode
`ifndef id_model_svh
`define id_model_svh

typedef struct packed {
    logic            illegal;
    alu_op_e         alu_op;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen-1:0] c;
    logic            rd_wr_en;
    logic [4:0]      rd;
    logic            branch;
    logic            jump;
    logic            rs1_use;
    logic            rs2_use;
} decoded_t;

logic [xlen-1:0] model_regs [32];
logic [31:0]     model_busy;

task automatic clear_model();
    model_regs = '{default: '0};
    model_busy = '0;
endtask

// architectural read as seen this cycle, write-back forwarded
function automatic logic [xlen-1:0] read_reg(input logic [4:0] addr);
    if (addr == 5'd0) return '0;
    if (wb_en && (wb_addr == addr)) return wb_data;
    return model_regs[addr];
endfunction

function automatic logic reg_is_busy(input logic [4:0] addr);
    if (addr == 5'd0) return 1'b0;
    if (wb_en && (wb_addr == addr)) return 1'b0;
    return model_busy[addr];
endfunction

function automatic decoded_t decode_ref(input logic [31:0] w, input logic [xlen-1:0] at_pc);
    decoded_t        d;
    logic [6:0]      opc;
    logic [2:0]      f3;
    logic [6:0]      f7;
    logic [xlen-1:0] i_imm;
    logic [xlen-1:0] u_imm;
    logic [xlen-1:0] b_imm;
    logic [xlen-1:0] j_imm;
    logic [xlen-1:0] r1;
    logic [xlen-1:0] r2;
    opc   = w[6:0];
    f3    = w[14:12];
    f7    = w[31:25];
    i_imm = {{20{w[31]}}, w[31:20]};
    u_imm = {w[31:12], 12'h000};
    b_imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    j_imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    r1    = read_reg(w[19:15]);
    r2    = read_reg(w[24:20]);
    d        = '0;
    d.alu_op = alu_add;
    d.rd     = w[11:7];
    case (opc)
        op_reg, op_imm: begin
            d.rd_wr_en = 1'b1;
            d.rs1_use  = 1'b1;
            d.rs2_use  = (opc == op_reg);
            d.a        = r1;
            d.b        = (opc == op_reg) ? r2 : i_imm;
            case (f3)
                f3_add_sub: begin
                    if (opc == op_imm || f7 == f7_base) d.alu_op = alu_add;
                    else if (f7 == f7_alt) d.alu_op = alu_sub;
                    else d.illegal = 1'b1;
                end
                f3_sll: begin
                    d.alu_op  = alu_sll;
                    d.illegal = (f7 != f7_base);
                end
                f3_srl_sra: begin
                    if (f7 == f7_base) d.alu_op = alu_srl;
                    else if (f7 == f7_alt) d.alu_op = alu_sra;
                    else d.illegal = 1'b1;
                end
                f3_slt:  d.alu_op = alu_slt;
                f3_sltu: d.alu_op = alu_sltu;
                f3_xor:  d.alu_op = alu_xor;
                f3_or:   d.alu_op = alu_or;
                default: d.alu_op = alu_and;
            endcase
        end
        op_lui: begin
            d.rd_wr_en = 1'b1;
            d.a        = u_imm;
        end
        op_auipc: begin
            d.rd_wr_en = 1'b1;
            d.a        = at_pc;
            d.b        = u_imm;
        end
        op_jal: begin
            d.rd_wr_en = 1'b1;
            d.jump     = 1'b1;
            d.a        = at_pc + j_imm;
            d.b        = at_pc;
        end
        op_jalr: begin
            d.rd_wr_en = 1'b1;
            d.jump     = 1'b1;
            d.rs1_use  = 1'b1;
            d.a        = r1 + i_imm;
            d.b        = at_pc;
        end
        op_branch: begin
            d.branch  = 1'b1;
            d.rs1_use = 1'b1;
            d.rs2_use = 1'b1;
            d.a       = r1;
            d.b       = r2;
            d.c       = b_imm;
            case (f3)
                f3_beq:  d.alu_op = alu_eq;
                f3_bne:  d.alu_op = alu_ne;
                f3_blt:  d.alu_op = alu_lt;
                f3_bge:  d.alu_op = alu_ge;
                f3_bltu: d.alu_op = alu_ltu;
                f3_bgeu: d.alu_op = alu_geu;
                default: d.illegal = 1'b1;
            endcase
        end
        default: d.illegal = 1'b1;
    endcase
    // an illegal word reads and writes nothing
    if (d.illegal) begin
        d          = '0;
        d.illegal  = 1'b1;
        d.alu_op   = alu_add;
        d.rd       = w[11:7];
    end
    return d;
endfunction

// register and busy update at a clock edge, a new claim beats a clear
task automatic commit_edge(input logic load, input decoded_t d);
    if (wb_en && (wb_addr != 5'd0)) begin
        model_regs[wb_addr] = wb_data;
        model_busy[wb_addr] = 1'b0;
    end
    if (load && d.rd_wr_en && (d.rd != 5'd0)) begin
        model_busy[d.rd] = 1'b1;
    end
endtask

`endif

//--- tb/tb_id_stage.sv
`timescale 1ns/1ps
// decode stage testbench
// random instructions and write-back checked against a reference model
module tb_id_stage
    import rv_isa_pkg::*;
    import id_ctrl_pkg::*;
();

    localparam int num_instr  = 2000;
    localparam int max_cycles = num_instr * 10;

    logic                  clk;
    logic                  reset_n;
    logic                  instr_valid;
    logic [xlen-1:0]       instr;
    logic [xlen-1:0]       pc;
    logic                  flush;
    logic                  ex_ready;
    logic                  id_ready;
    logic                  wb_en;
    logic [reg_addr_w-1:0] wb_addr;
    logic [xlen-1:0]       wb_data;
    logic                  ex_valid;
    alu_op_e               ex_alu_op;
    logic [xlen-1:0]       ex_src_a;
    logic [xlen-1:0]       ex_src_b;
    logic [xlen-1:0]       ex_src_c;
    logic                  ex_rd_wr_en;
    logic [reg_addr_w-1:0] ex_rd_addr;
    logic                  ex_branch;
    logic                  ex_jump;
    logic                  ex_illegal;

    // expected EX register contents
    logic            exp_valid;
    logic            exp_rd_wr_en;
    logic            exp_branch;
    logic            exp_jump;
    logic            exp_illegal;
    alu_op_e         exp_alu;
    logic [xlen-1:0] exp_a;
    logic [xlen-1:0] exp_b;
    logic [xlen-1:0] exp_c;
    logic [4:0]      exp_rd;

    logic [31:0] rng_state;
    logic        xfer;
    int          done;
    int          cycles;
    int          error_count;

    `include "id_model.svh"

    id_stage #(
        .num_regs (32)
    ) UUT (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: only %0d of %0d instructions done in %0d cycles",
                     done, num_instr, cycles);
            $display("Simulation failed");
            $fatal(1, "timeout");
        end
    end

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            error_count++;
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, expected);
            $display("Simulation failed");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    // mostly x0..x7 so hazards come up often
    function automatic logic [4:0] pick_reg();
        logic [31:0] r;
        r = next_rand();
        if (r[7:6] != 2'b00) return {2'b00, r[2:0]};
        return r[12:8];
    endfunction

    ////////////////////
    task automatic make_instr();
        logic [31:0] w;
        logic [31:0] r;
        int          kind;
        w        = next_rand();
        r        = next_rand();
        w[11:7]  = pick_reg();
        w[19:15] = pick_reg();
        w[24:20] = pick_reg();
        kind     = int'(next_rand() % 32'd16);
        if (kind == 0) begin
            case (r[4:3])
                2'd0: w[6:0] = 7'b0000011;
                2'd1: begin
                    w[6:0]   = op_reg;
                    w[14:12] = f3_add_sub;
                    w[31:25] = 7'b0000001;
                end
                2'd2: begin
                    w[6:0]   = r[5] ? op_reg : op_imm;
                    w[14:12] = f3_sll;
                    w[31:25] = 7'b0000001;
                end
                default: begin
                    w[6:0]   = op_branch;
                    w[14:12] = {2'b01, r[2]};
                end
            endcase
        end else begin
            case ((kind - 1) % 7)
                0: begin
                    w[6:0] = op_reg;
                    if (w[14:12] == f3_add_sub || w[14:12] == f3_srl_sra)
                        w[31:25] = r[0] ? f7_alt : f7_base;
                    else
                        w[31:25] = f7_base;
                end
                1: begin
                    w[6:0] = op_imm;
                    if (w[14:12] == f3_sll) w[31:25] = f7_base;
                    if (w[14:12] == f3_srl_sra) w[31:25] = r[1] ? f7_alt : f7_base;
                end
                2: w[6:0] = op_lui;
                3: w[6:0] = op_auipc;
                4: w[6:0] = op_jal;
                5: begin
                    w[6:0]   = op_jalr;
                    w[14:12] = 3'b000;
                end
                default: begin
                    w[6:0] = op_branch;
                    // 010 and 011 are not branches
                    if (w[14:13] == 2'b01) w[14] = 1'b1;
                end
            endcase
        end
        instr = w;
        r     = next_rand();
        pc    = {r[31:2], 2'b00};
    endtask

    task automatic drive_inputs();
        logic [31:0] r;
        logic [4:0]  start;
        logic [4:0]  idx;
        r           = next_rand();
        instr_valid = (r[2:0] != 3'd0);
        ex_ready    = (r[4:3] != 2'd0);
        flush       = ((next_rand() % 32'd20) == 32'd0);
        wb_en       = 1'b0;
        wb_addr     = '0;
        wb_data     = next_rand();
        start       = r[16:12];
        if (r[11:10] != 2'd0) begin
            for (int i = 0; i < 32; i++) begin
                idx = start + 5'(i);
                if (!wb_en && model_busy[idx]) begin
                    wb_en   = 1'b1;
                    wb_addr = idx;
                end
            end
        end else if (r[18:17] == 2'd0) begin
            // x0 write must be ignored
            wb_en = 1'b1;
        end
    endtask

    ////////////////////
    // inputs are stable here, work out the coming edge
    task automatic predict_edge();
        decoded_t d;
        logic     ready;
        logic     load;
        d     = decode_ref(instr, pc);
        ready = ex_ready && !(d.rs1_use && reg_is_busy(instr[19:15]))
                && !(d.rs2_use && reg_is_busy(instr[24:20]))
                && !(d.rd_wr_en && reg_is_busy(d.rd));
        check_value("id_ready", 32'(id_ready), 32'(ready));
        xfer = instr_valid && ready;
        load = xfer && !flush;
        if (flush || ex_ready) begin
            exp_valid    = load;
            exp_rd_wr_en = load && d.rd_wr_en;
            exp_branch   = load && d.branch;
            exp_jump     = load && d.jump;
            exp_illegal  = load && d.illegal;
        end
        if (load) begin
            exp_alu = d.alu_op;
            exp_a   = d.a;
            exp_b   = d.b;
            exp_c   = d.c;
            exp_rd  = d.rd;
        end
        commit_edge(load, d);
    endtask

    task automatic check_ex();
        check_value("ex_valid", 32'(ex_valid), 32'(exp_valid));
        check_value("ex_rd_wr_en", 32'(ex_rd_wr_en), 32'(exp_rd_wr_en));
        check_value("ex_branch", 32'(ex_branch), 32'(exp_branch));
        check_value("ex_jump", 32'(ex_jump), 32'(exp_jump));
        check_value("ex_illegal", 32'(ex_illegal), 32'(exp_illegal));
        if (exp_valid) begin
            check_value("ex_alu_op", 32'(ex_alu_op), 32'(exp_alu));
            check_value("ex_src_a", ex_src_a, exp_a);
            check_value("ex_src_b", ex_src_b, exp_b);
            check_value("ex_src_c", ex_src_c, exp_c);
            check_value("ex_rd_addr", 32'(ex_rd_addr), 32'(exp_rd));
        end
    endtask

    ////////////////////
    initial begin
        clk          = 1'b0;
        reset_n      = 1'b0;
        instr_valid  = 1'b0;
        instr        = '0;
        pc           = '0;
        flush        = 1'b0;
        ex_ready     = 1'b1;
        wb_en        = 1'b0;
        wb_addr      = '0;
        wb_data      = '0;
        rng_state    = 32'd11321;
        exp_valid    = 1'b0;
        exp_rd_wr_en = 1'b0;
        exp_branch   = 1'b0;
        exp_jump     = 1'b0;
        exp_illegal  = 1'b0;
        exp_alu      = alu_add;
        exp_a        = '0;
        exp_b        = '0;
        exp_c        = '0;
        exp_rd       = '0;
        xfer         = 1'b0;
        done         = 0;
        cycles       = 0;
        error_count  = 0;
        clear_model();

        repeat (8) @(posedge clk);
        #1;
        reset_n = 1'b1;
        check_value("ex_valid after reset", 32'(ex_valid), 32'd0);
        check_value("ex_rd_wr_en after reset", 32'(ex_rd_wr_en), 32'd0);

        make_instr();
        while (done < num_instr) begin
            drive_inputs();
            @(negedge clk);
            predict_edge();
            @(posedge clk);
            #1;
            check_ex();
            // hold the word until it transfers
            if (xfer) begin
                done++;
                make_instr();
            end
        end

        if (error_count == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            $display("Simulation failed");
            $fatal(1, "%0d checks failed", error_count);
        end
    end

endmodule

//--- tb/id_stage_checker.sv
`timescale 1ns/1ps
// handshake and reset assertions for the decode stage
module id_stage_checker
    import rv_isa_pkg::*;
    import id_ctrl_pkg::*;
(
    input logic                  clk,
    input logic                  reset_n,
    input logic                  flush,
    input logic                  ex_ready,
    input logic                  id_ready,
    input logic                  ex_valid,
    input alu_op_e               ex_alu_op,
    input logic [xlen-1:0]       ex_src_a,
    input logic [xlen-1:0]       ex_src_b,
    input logic [xlen-1:0]       ex_src_c,
    input logic                  ex_rd_wr_en,
    input logic [reg_addr_w-1:0] ex_rd_addr,
    input logic                  ex_branch,
    input logic                  ex_jump,
    input logic                  ex_illegal
);

    reset_clears_ex: assert property (@(posedge clk)
        $rose(reset_n) |-> !ex_valid && !ex_rd_wr_en)
        else $error("EX valid or write enable set out of reset");

    // EX stalled, nothing may move
    ex_holds: assert property (@(posedge clk) disable iff (!reset_n)
        ex_valid && !ex_ready && !flush |=> $stable(ex_valid) && $stable(ex_alu_op)
            && $stable(ex_src_a) && $stable(ex_src_b) && $stable(ex_src_c)
            && $stable(ex_rd_wr_en) && $stable(ex_rd_addr) && $stable(ex_branch)
            && $stable(ex_jump) && $stable(ex_illegal))
        else $error("EX outputs changed while ex_ready was low");

    ready_needs_ex: assert property (@(posedge clk) disable iff (!reset_n)
        id_ready |-> ex_ready)
        else $error("id_ready high while ex_ready low");

    flush_bubble: assert property (@(posedge clk) disable iff (!reset_n)
        flush |=> !ex_valid)
        else $error("ex_valid high after flush");

endmodule

bind id_stage id_stage_checker u_checker (.*);

//--- hw/id_stage.sv
`timescale 1ns/1ps
// decode stage top level
module id_stage
    import rv_isa_pkg::*;
    import id_ctrl_pkg::*;
#(
    parameter int num_regs = 32
) (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  instr_valid,
    input  logic [xlen-1:0]       instr,
    input  logic [xlen-1:0]       pc,
    input  logic                  flush,
    input  logic                  ex_ready,
    output logic                  id_ready,
    // write-back
    input  logic                  wb_en,
    input  logic [reg_addr_w-1:0] wb_addr,
    input  logic [xlen-1:0]       wb_data,
    // to EX
    output logic                  ex_valid,
    output alu_op_e               ex_alu_op,
    output logic [xlen-1:0]       ex_src_a,
    output logic [xlen-1:0]       ex_src_b,
    output logic [xlen-1:0]       ex_src_c,
    output logic                  ex_rd_wr_en,
    output logic [reg_addr_w-1:0] ex_rd_addr,
    output logic                  ex_branch,
    output logic                  ex_jump,
    output logic                  ex_illegal
);

    alu_op_e               alu_op;
    src_a_sel_e            src_a_sel;
    src_b_sel_e            src_b_sel;
    src_c_sel_e            src_c_sel;
    logic                  rd_wr_en;
    logic [reg_addr_w-1:0] rd_addr;
    logic [xlen-1:0]       imm_i;
    logic [xlen-1:0]       imm_u;
    logic [xlen-1:0]       imm_b;
    logic [xlen-1:0]       imm_j;
    logic                  branch;
    logic                  jump;
    logic                  illegal;
    logic [xlen-1:0]       src_a;
    logic [xlen-1:0]       src_b;
    logic [xlen-1:0]       src_c;
    logic                  rd_busy;
    logic                  claim_en;

    rf_read_if #(.data_w(xlen), .addr_w(reg_addr_w)) rs1_port ();
    rf_read_if #(.data_w(xlen), .addr_w(reg_addr_w)) rs2_port ();

    ////////////////////
    instr_decoder u_decoder (.*);

    operand_mux u_operand_mux (.*);

    reg_file #(
        .num_regs (num_regs)
    ) u_reg_file (
        .claim_addr (rd_addr),
        .*
    );

    id_ex_reg u_id_ex_reg (.*);

endmodule

//--- hw/id_ex_reg.sv
`timescale 1ns/1ps
// decode stall logic and the ID/EX pipeline register
module id_ex_reg
    import rv_isa_pkg::*;
    import id_ctrl_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  instr_valid,
    input  logic                  flush,
    input  logic                  ex_ready,
    rf_read_if.requester          rs1_port,
    rf_read_if.requester          rs2_port,
    input  logic                  rd_busy,
    input  logic                  rd_wr_en,
    input  logic [reg_addr_w-1:0] rd_addr,
    input  alu_op_e               alu_op,
    input  logic [xlen-1:0]       src_a,
    input  logic [xlen-1:0]       src_b,
    input  logic [xlen-1:0]       src_c,
    input  logic                  branch,
    input  logic                  jump,
    input  logic                  illegal,
    output logic                  id_ready,
    output logic                  claim_en,
    output logic                  ex_valid,
    output alu_op_e               ex_alu_op,
    output logic [xlen-1:0]       ex_src_a,
    output logic [xlen-1:0]       ex_src_b,
    output logic [xlen-1:0]       ex_src_c,
    output logic                  ex_rd_wr_en,
    output logic [reg_addr_w-1:0] ex_rd_addr,
    output logic                  ex_branch,
    output logic                  ex_jump,
    output logic                  ex_illegal
);

    logic xfer;
    logic load;

    // RAW on either source, WAW on the destination
    assign id_ready = ex_ready && !rs1_port.busy && !rs2_port.busy && !(rd_wr_en && rd_busy);
    assign xfer     = instr_valid && id_ready;
    assign load     = xfer && !flush;
    assign claim_en = load && rd_wr_en && (rd_addr != '0);

    ////////////////////
    // flush forces a bubble even when EX stalls
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ex_valid    <= 1'b0;
            ex_rd_wr_en <= 1'b0;
            ex_branch   <= 1'b0;
            ex_jump     <= 1'b0;
            ex_illegal  <= 1'b0;
        end else if (flush || ex_ready) begin
            ex_valid    <= load;
            ex_rd_wr_en <= load && rd_wr_en;
            ex_branch   <= load && branch;
            ex_jump     <= load && jump;
            ex_illegal  <= load && illegal;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            ex_alu_op  <= alu_op;
            ex_src_a   <= src_a;
            ex_src_b   <= src_b;
            ex_src_c   <= src_c;
            ex_rd_addr <= rd_addr;
        end
    end

endmodule

//--- hw/reg_file.sv
`timescale 1ns/1ps
// integer register file with busy bits
// two bypassed read ports, one write-back port
module reg_file
    import rv_isa_pkg::*;
#(
    parameter int num_regs = 32
) (
    input  logic                  clk,
    input  logic                  reset_n,
    rf_read_if.provider           rs1_port,
    rf_read_if.provider           rs2_port,
    input  logic                  claim_en,
    input  logic [reg_addr_w-1:0] claim_addr,
    output logic                  rd_busy,
    input  logic                  wb_en,
    input  logic [reg_addr_w-1:0] wb_addr,
    input  logic [xlen-1:0]       wb_data
);

    logic [xlen-1:0]     regs [num_regs];
    logic [num_regs-1:0] busy;

    // x0 reads zero, write-back in the same cycle wins over storage
    function automatic logic [xlen-1:0] read_data(input logic [reg_addr_w-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        if (wb_en && (wb_addr == addr)) begin
            return wb_data;
        end
        return regs[addr];
    endfunction

    function automatic logic read_busy(input logic en, input logic [reg_addr_w-1:0] addr);
        return en && (addr != '0) && busy[addr] && !(wb_en && (wb_addr == addr));
    endfunction

    always_comb begin
        rs1_port.data = read_data(rs1_port.addr);
        rs1_port.busy = read_busy(rs1_port.en, rs1_port.addr);
        rs2_port.data = read_data(rs2_port.addr);
        rs2_port.busy = read_busy(rs2_port.en, rs2_port.addr);
        rd_busy       = read_busy(1'b1, claim_addr);
    end

    ////////////////////
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy <= '0;
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wb_en && (wb_addr != '0)) begin
                regs[wb_addr] <= wb_data;
                busy[wb_addr] <= 1'b0;
            end
            // a new claim overrides a clear on the same register
            if (claim_en && (claim_addr != '0)) begin
                busy[claim_addr] <= 1'b1;
            end
        end
    end

endmodule

//--- hw/operand_mux.sv
`timescale 1ns/1ps
// jump target adder and EX operand selection
module operand_mux
    import rv_isa_pkg::*;
    import id_ctrl_pkg::*;
(
    input  logic [xlen-1:0] pc,
    rf_read_if.requester    rs1_port,
    rf_read_if.requester    rs2_port,
    input  logic [xlen-1:0] imm_i,
    input  logic [xlen-1:0] imm_u,
    input  logic [xlen-1:0] imm_b,
    input  logic [xlen-1:0] imm_j,
    input  logic            jump,
    input  src_a_sel_e      src_a_sel,
    input  src_b_sel_e      src_b_sel,
    input  src_c_sel_e      src_c_sel,
    output logic [xlen-1:0] src_a,
    output logic [xlen-1:0] src_b,
    output logic [xlen-1:0] src_c
);

    logic [xlen-1:0] tgt_base;
    logic [xlen-1:0] tgt_offset;
    logic [xlen-1:0] jump_target;

    // jalr reads rs1, jal does not; adder idles off jumps
    assign tgt_base    = !jump ? '0 : (rs1_port.en ? rs1_port.data : pc);
    assign tgt_offset  = !jump ? '0 : (rs1_port.en ? imm_i : imm_j);
    assign jump_target = tgt_base + tgt_offset;

    always_comb begin
        case (src_a_sel)
            src_a_rs1:   src_a = rs1_port.data;
            src_a_pc:    src_a = pc;
            src_a_imm_u: src_a = imm_u;
            src_a_jump:  src_a = jump_target;
            default:     src_a = '0;
        endcase
    end

    always_comb begin
        case (src_b_sel)
            src_b_rs2:   src_b = rs2_port.data;
            src_b_imm_i: src_b = imm_i;
            src_b_imm_u: src_b = imm_u;
            src_b_pc:    src_b = pc;
            default:     src_b = '0;
        endcase
    end

    assign src_c = (src_c_sel == src_c_imm_b) ? imm_b : '0;

endmodule

//--- hw/instr_decoder.sv
`timescale 1ns/1ps
// RV32I instruction decoder
// control fields, register read requests and immediates
module instr_decoder
    import rv_isa_pkg::*;
    import id_ctrl_pkg::*;
(
    input  logic [xlen-1:0]       instr,
    rf_read_if.requester          rs1_port,
    rf_read_if.requester          rs2_port,
    output alu_op_e               alu_op,
    output src_a_sel_e            src_a_sel,
    output src_b_sel_e            src_b_sel,
    output src_c_sel_e            src_c_sel,
    output logic                  rd_wr_en,
    output logic [reg_addr_w-1:0] rd_addr,
    output logic [xlen-1:0]       imm_i,
    output logic [xlen-1:0]       imm_u,
    output logic [xlen-1:0]       imm_b,
    output logic [xlen-1:0]       imm_j,
    output logic                  branch,
    output logic                  jump,
    output logic                  illegal
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       rs1_use;
    logic       rs2_use;

    assign opcode  = opcode_e'(instr[6:0]);
    assign funct3  = instr[14:12];
    assign funct7  = instr[31:25];
    assign rd_addr = instr[11:7];

    assign rs1_port.en   = rs1_use;
    assign rs1_port.addr = instr[19:15];
    assign rs2_port.en   = rs2_use;
    assign rs2_port.addr = instr[24:20];

    ////////////////////
    // sign-extended immediates
    assign imm_i = {{(xlen-12){instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_b = {{(xlen-12){instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{(xlen-20){instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    ////////////////////
    always_comb begin
        alu_op    = alu_add;
        src_a_sel = src_a_zero;
        src_b_sel = src_b_zero;
        src_c_sel = src_c_zero;
        rd_wr_en  = 1'b0;
        rs1_use   = 1'b0;
        rs2_use   = 1'b0;
        branch    = 1'b0;
        jump      = 1'b0;
        illegal   = 1'b0;

        case (opcode)
            op_reg, op_imm: begin
                src_a_sel = src_a_rs1;
                src_b_sel = (opcode == op_reg) ? src_b_rs2 : src_b_imm_i;
                rd_wr_en  = 1'b1;
                rs1_use   = 1'b1;
                rs2_use   = (opcode == op_reg);
                case (funct3)
                    f3_add_sub: begin
                        // addi has no sub form
                        if (opcode == op_reg) begin
                            if (funct7 == f7_alt) begin
                                alu_op = alu_sub;
                            end else if (funct7 != f7_base) begin
                                illegal = 1'b1;
                            end
                        end
                    end
                    f3_sll: begin
                        alu_op  = alu_sll;
                        illegal = (funct7 != f7_base);
                    end
                    f3_srl_sra: begin
                        alu_op  = (funct7 == f7_alt) ? alu_sra : alu_srl;
                        illegal = (funct7 != f7_base) && (funct7 != f7_alt);
                    end
                    f3_slt:  alu_op = alu_slt;
                    f3_sltu: alu_op = alu_sltu;
                    f3_xor:  alu_op = alu_xor;
                    f3_or:   alu_op = alu_or;
                    default: alu_op = alu_and;
                endcase
            end
            op_lui: begin
                src_a_sel = src_a_imm_u;
                rd_wr_en  = 1'b1;
            end
            op_auipc: begin
                src_a_sel = src_a_pc;
                src_b_sel = src_b_imm_u;
                rd_wr_en  = 1'b1;
            end
            op_jal, op_jalr: begin
                // target on A, pc on B for the link value
                src_a_sel = src_a_jump;
                src_b_sel = src_b_pc;
                rd_wr_en  = 1'b1;
                rs1_use   = (opcode == op_jalr);
                jump      = 1'b1;
            end
            op_branch: begin
                src_a_sel = src_a_rs1;
                src_b_sel = src_b_rs2;
                src_c_sel = src_c_imm_b;
                rs1_use   = 1'b1;
                rs2_use   = 1'b1;
                branch    = 1'b1;
                case (funct3)
                    f3_beq:  alu_op = alu_eq;
                    f3_bne:  alu_op = alu_ne;
                    f3_blt:  alu_op = alu_lt;
                    f3_bge:  alu_op = alu_ge;
                    f3_bltu: alu_op = alu_ltu;
                    f3_bgeu: alu_op = alu_geu;
                    default: illegal = 1'b1;
                endcase
            end
            default: illegal = 1'b1;
        endcase

        // illegal words read nothing and write nothing
        if (illegal) begin
            alu_op    = alu_add;
            src_a_sel = src_a_zero;
            src_b_sel = src_b_zero;
            src_c_sel = src_c_zero;
            rd_wr_en  = 1'b0;
            rs1_use   = 1'b0;
            rs2_use   = 1'b0;
            branch    = 1'b0;
        end
    end

endmodule

//--- hw/rf_read_if.sv
`timescale 1ns/1ps
// one register file read port with busy status
interface rf_read_if #(
    parameter int data_w = 32,
    parameter int addr_w = 5
);

    logic              en;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] data;
    logic              busy;

    modport requester (
        output en, addr,
        input  data, busy
    );

    modport provider (
        input  en, addr,
        output data, busy
    );

endinterface

//--- hw/id_ctrl_pkg.sv
// decode stage micro-op types
// ALU operation and EX operand selects
package id_ctrl_pkg;

    typedef enum logic [4:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        // branch compares
        alu_eq,
        alu_ne,
        alu_lt,
        alu_ge,
        alu_ltu,
        alu_geu
    } alu_op_e;

    typedef enum logic [2:0] {
        src_a_rs1,
        src_a_pc,
        src_a_imm_u,
        src_a_jump,
        src_a_zero
    } src_a_sel_e;

    typedef enum logic [2:0] {
        src_b_rs2,
        src_b_imm_i,
        src_b_imm_u,
        src_b_pc,
        src_b_zero
    } src_b_sel_e;

    // branch offset for EX
    typedef enum logic {
        src_c_imm_b,
        src_c_zero
    } src_c_sel_e;

endpackage

//--- hw/rv_isa_pkg.sv
// RV32I encoding definitions
// architectural widths, major opcodes, funct3 and funct7 values
package rv_isa_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // major opcodes handled by decode
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011
    } opcode_e;

    ////////////////////
    // funct3, arithmetic group
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // funct3, branch group
    localparam logic [2:0] f3_beq     = 3'b000;
    localparam logic [2:0] f3_bne     = 3'b001;
    localparam logic [2:0] f3_blt     = 3'b100;
    localparam logic [2:0] f3_bge     = 3'b101;
    localparam logic [2:0] f3_bltu    = 3'b110;
    localparam logic [2:0] f3_bgeu    = 3'b111;

    ////////////////////
    localparam logic [6:0] f7_base    = 7'b0000000;
    // selects sub and sra
    localparam logic [6:0] f7_alt     = 7'b0100000;

endpackage
